//--- Makefile
TOP = tb_zkbd

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- compile.f
zkbd_pkg.sv
slavespi.sv
zkbdmus.sv
zports.sv
zkbd_top.sv
tb_zkbd.sv

//--- slavespi.sv
`timescale 1ns/100ps

module slavespi(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  logic                  spics_n,
	input  logic                  spick,
	input  logic                  spido,

	output zkbd_pkg::kbd_matrix_u kbd_out,
	output logic                  kbd_stb,
	output logic [4:0]            kj_out,
	output logic                  kj_stb
);

	import zkbd_pkg::*;

	logic [2:0]  cs_sync;
	logic [2:0]  ck_sync;
	logic [1:0]  do_sync;

	logic        cs_rise;
	logic        cs_fall;
	logic        sck_rise;
	logic        sdo;

	logic [2:0]  bit_cnt;
	logic [3:0]  byte_cnt;
	logic [7:0]  code;
	logic [6:0]  rx_byte;
	logic [7:0]  byte_full;
	kbd_matrix_u shreg;

	logic        kbd_hit;
	logic        kj_hit;

	////////////////////////////////////////////////////////////
	// pin synchronizers and edges
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			cs_sync <= 3'b111;
			ck_sync <= 3'b000;
			do_sync <= 2'b00;
		end
		else
		begin
			cs_sync <= {cs_sync[1:0], spics_n};
			ck_sync <= {ck_sync[1:0], spick};
			do_sync <= {do_sync[0], spido};
		end
	end

	assign cs_rise  =  cs_sync[1] & ~cs_sync[2];
	assign cs_fall  = ~cs_sync[1] &  cs_sync[2];
	// mode 0, sample on rising sck while selected
	assign sck_rise =  ck_sync[1] & ~ck_sync[2] & ~cs_sync[1];
	assign sdo      =  do_sync[1];

	assign byte_full = {rx_byte, sdo};

	////////////////////////////////////////////////////////////
	// bit and byte framing
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			bit_cnt  <= 3'd0;
			byte_cnt <= 4'd0;
			code     <= 8'd0;
		end
		else if (cs_fall)
		begin
			bit_cnt  <= 3'd0;
			byte_cnt <= 4'd0;
		end
		else if (sck_rise)
		begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7)
			begin
				if (byte_cnt == 4'd0)
					code <= byte_full;
				// saturate on long frames
				if (byte_cnt != 4'hF)
					byte_cnt <= byte_cnt + 4'd1;
			end
		end
	end

	// data bytes shift in msb first, first byte ends up on top
	always_ff @(posedge fclk)
	begin
		if (sck_rise)
		begin
			rx_byte <= {rx_byte[5:0], sdo};
			if (bit_cnt == 3'd7 && byte_cnt != 4'd0)
				shreg.flat <= {shreg.flat[KBD_BITS-9:0], byte_full};
		end
	end

	////////////////////////////////////////////////////////////
	// end of frame
	////////////////////////////////////////////////////////////

	assign kbd_hit = (code == SPI_ADDR_KBD) && (bit_cnt == 3'd0) &&
	                 (byte_cnt == 4'(KBD_BYTES + 1));
	assign kj_hit  = (code == SPI_ADDR_KJ) && (bit_cnt == 3'd0) &&
	                 (byte_cnt >= 4'd2);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			kbd_stb <= 1'b0;
			kj_stb  <= 1'b0;
		end
		else
		begin
			kbd_stb <= cs_rise & kbd_hit;
			kj_stb  <= cs_rise & kj_hit;
		end
	end

	assign kbd_out = shreg;
	// last full byte received
	assign kj_out  = shreg.flat[4:0];

	a_one_stb: assert property (@(posedge fclk) disable iff (!rst_n)
		!(kbd_stb && kj_stb));

endmodule

//--- tb_zkbd.sv
`timescale 1ns/100ps

module tb_zkbd;

	import zkbd_pkg::*;

	localparam int N_TXN           = 300;
	// longest frame is 7 bytes of 16 fclk per bit plus framing gaps
	localparam int LONG_TXN_CYCLES = 7 * 8 * 16 + 64;
	localparam int WATCHDOG_NS     = N_TXN * LONG_TXN_CYCLES * 4 + 100000;

	logic        fclk;
	logic        rst_n;
	logic        spics_n;
	logic        spick;
	logic        spido;
	logic        iorq_n;
	logic        rd_n;
	logic [15:0] a;
	logic [7:0]  dout;
	logic        dataout;

	integer      seed;
	int          txn_count;
	kbd_matrix_u model_mat;
	logic [4:0]  model_kj;
	logic [7:0]  frame_data [0:7];

	zkbd_top UUT( .fclk(fclk), .rst_n(rst_n),
	              .spics_n(spics_n), .spick(spick), .spido(spido),
	              .iorq_n(iorq_n), .rd_n(rd_n), .a(a),
	              .dout(dout), .dataout(dataout) );

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all transactions completed");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		logic [31:0] w;
		w = $random(seed);
		return int'(w % 32'(n));
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] w;
		w = $random(seed);
		return w[7:0];
	endfunction

	// column c reads low if any selected row has key c pressed
	function automatic logic [4:0] expected_kbd(input logic [7:0] zah);
		logic [4:0] res;
		res = 5'b11111;
		for (int c = 0; c < KBD_COLS; c++)
			for (int r = 0; r < KBD_ROWS; r++)
				if (!zah[r] && !model_mat.rows[r][c])
					res[c] = 1'b0;
		return res;
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge fclk);
		#1;
	endtask

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp_byte,
	                           input string what);
		assert (got === exp_byte)
		else
		begin
			$display("FAILED %0t: %s is %02h, expected %02h", $time, what, got, exp_byte);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_flag(input logic got, input logic exp_bit, input string what);
		assert (got === exp_bit)
		else
		begin
			$display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp_bit);
			$display("Simulation FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////
	// spi host
	////////////////////////////////////////////////////////////

	task automatic send_bits(input logic [7:0] b, input int n);
		for (int i = 7; i > 7 - n; i--)
		begin
			spido = b[i];
			step(8);
			spick = 1'b1;
			step(8);
			spick = 1'b0;
		end
	endtask

	task automatic send_frame(input logic [7:0] code, input int nbytes, input int cut_bits);
		for (int i = 0; i < nbytes; i++)
			frame_data[i] = rand_byte();
		spics_n = 1'b0;
		step(8);
		send_bits(code, 8);
		for (int i = 0; i < nbytes; i++)
			send_bits(frame_data[i], 8);
		if (cut_bits > 0)
			send_bits(rand_byte(), cut_bits);
		step(8);
		spics_n = 1'b1;
		step(8);
		if (cut_bits == 0 && code == SPI_ADDR_KBD && nbytes == KBD_BYTES)
			model_mat.flat = {frame_data[0], frame_data[1], frame_data[2],
			                  frame_data[3], frame_data[4]};
		if (cut_bits == 0 && code == SPI_ADDR_KJ && nbytes >= 1)
			model_kj = frame_data[nbytes-1][4:0];
		txn_count++;
	endtask

	task automatic bad_frame();
		logic [7:0] code;
		case (rand_below(5))
			0:
			begin
				do
					code = rand_byte();
				while (code == SPI_ADDR_KBD || code == SPI_ADDR_KJ);
				send_frame(code, 1 + rand_below(5), 0);
			end
			1: send_frame(SPI_ADDR_KBD, 4, 0);
			2: send_frame(SPI_ADDR_KBD, 6, 0);
			3: send_frame(rand_below(2) == 0 ? SPI_ADDR_KBD : SPI_ADDR_KJ,
			              rand_below(6), 1 + rand_below(7));
			default: send_frame(SPI_ADDR_KJ, 0, 0);
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////

	task automatic z80_cycle(input logic [15:0] addr, input logic iorq_v, input logic rd_v);
		logic       drive;
		logic [7:0] exp_byte;
		drive    = 1'b0;
		exp_byte = 8'h00;
		if (!iorq_v && !rd_v && addr[7:0] == PORT_KBD)
		begin
			drive    = 1'b1;
			exp_byte = {3'b111, expected_kbd(addr[15:8])};
		end
		else if (!iorq_v && !rd_v && addr[7:0] == PORT_KJ)
		begin
			drive    = 1'b1;
			exp_byte = {3'b000, model_kj};
		end
		a      = addr;
		iorq_n = iorq_v;
		rd_n   = rd_v;
		for (int i = 0; i < 10; i++)
		begin
			step(1);
			if (!drive)
				check_flag(dataout, 1'b0, "dataout outside a port read");
		end
		if (drive)
		begin
			check_flag(dataout, 1'b1, "dataout during port read");
			check_value(dout, exp_byte, "dout");
		end
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		step(4);
		check_flag(dataout, 1'b0, "dataout after bus release");
		txn_count++;
	endtask

	// select one row at a time
	task automatic read_each_row();
		for (int r = 0; r < KBD_ROWS; r++)
			z80_cycle({~(8'h01 << r), PORT_KBD}, 1'b0, 1'b0);
	endtask

	task automatic other_port_read();
		logic [7:0] lo;
		do
			lo = rand_byte();
		while (lo == PORT_KBD || lo == PORT_KJ);
		z80_cycle({rand_byte(), lo}, 1'b0, 1'b0);
	endtask

	task automatic partial_cycle();
		logic [7:0] lo;
		lo = rand_below(2) == 0 ? PORT_KBD : PORT_KJ;
		case (rand_below(3))
			0: z80_cycle({rand_byte(), lo}, 1'b0, 1'b1);
			1: z80_cycle({rand_byte(), lo}, 1'b1, 1'b0);
			default: z80_cycle({rand_byte(), lo}, 1'b1, 1'b1);
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		seed      = 24992;
		txn_count = 0;
		model_mat.flat = '1;
		model_kj  = 5'd0;
		rst_n     = 1'b0;
		spics_n   = 1'b1;
		spick     = 1'b0;
		spido     = 1'b0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		a         = 16'h0000;
		repeat (10) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		step(4);

		// idle state after reset
		z80_cycle({rand_byte(), PORT_KBD}, 1'b0, 1'b0);
		z80_cycle({rand_byte(), PORT_KJ}, 1'b0, 1'b0);

		send_frame(SPI_ADDR_KBD, KBD_BYTES, 0);
		z80_cycle({8'h00, PORT_KBD}, 1'b0, 1'b0);
		z80_cycle({8'hFF, PORT_KBD}, 1'b0, 1'b0);
		z80_cycle({rand_byte(), PORT_KBD}, 1'b0, 1'b0);
		read_each_row();

		send_frame(SPI_ADDR_KJ, 1, 0);
		z80_cycle({rand_byte(), PORT_KJ}, 1'b0, 1'b0);
		read_each_row();

		// frames that must not load
		send_frame(8'h42, 3, 0);
		send_frame(SPI_ADDR_KBD, 4, 0);
		send_frame(SPI_ADDR_KBD, 6, 0);
		send_frame(SPI_ADDR_KBD, 5, 3);
		read_each_row();
		z80_cycle({rand_byte(), PORT_KJ}, 1'b0, 1'b0);

		other_port_read();
		partial_cycle();

		while (txn_count < N_TXN)
		begin
			case (rand_below(10))
				0, 1: send_frame(SPI_ADDR_KBD, KBD_BYTES, 0);
				2: send_frame(SPI_ADDR_KJ, 1 + rand_below(3), 0);
				3: bad_frame();
				4, 5, 6: z80_cycle({rand_byte(), PORT_KBD}, 1'b0, 1'b0);
				7: z80_cycle({rand_byte(), PORT_KJ}, 1'b0, 1'b0);
				8: other_port_read();
				default: partial_cycle();
			endcase
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- zkbd_pkg.sv
package zkbd_pkg;

	////////////////////////////////////////////////////////////
	// key matrix geometry
	////////////////////////////////////////////////////////////

	localparam int KBD_ROWS  = 8;
	localparam int KBD_COLS  = 5;
	localparam int KBD_BITS  = KBD_ROWS * KBD_COLS;

	// data bytes after the register code in a keyboard frame
	localparam int KBD_BYTES = KBD_BITS / 8;

	////////////////////////////////////////////////////////////
	// spi register codes
	////////////////////////////////////////////////////////////

	localparam logic [7:0] SPI_ADDR_KBD = 8'h10;
	localparam logic [7:0] SPI_ADDR_KJ  = 8'h11;

	////////////////////////////////////////////////////////////
	// z80 i/o ports, low address byte
	////////////////////////////////////////////////////////////

	localparam logic [7:0] PORT_KBD = 8'hFE;
	localparam logic [7:0] PORT_KJ  = 8'h1F;

	// flat view is the spi shift register, first byte in 39..32
	// row view: row r sits at bits 5r+4..5r, keys active low
	typedef union packed
	{
		logic [KBD_BITS-1:0]                flat;
		logic [KBD_ROWS-1:0][KBD_COLS-1:0] rows;
	} kbd_matrix_u;

endpackage

//--- zkbd_top.sv
`timescale 1ns/100ps

module zkbd_top(
	input  logic        fclk,
	input  logic        rst_n,

	input  logic        spics_n,
	input  logic        spick,
	input  logic        spido,

	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic [15:0] a,

	output logic [7:0]  dout,
	output logic        dataout
);

	import zkbd_pkg::*;

	kbd_matrix_u kbd_bus;
	logic        kbd_stb;
	logic [4:0]  kj_bus;
	logic        kj_stb;

	logic [4:0]  kbd_port_data;
	logic [4:0]  kj_port_data;

	slavespi slavespi( .fclk(fclk), .rst_n(rst_n),
	                   .spics_n(spics_n), .spick(spick), .spido(spido),
	                   .kbd_out(kbd_bus), .kbd_stb(kbd_stb),
	                   .kj_out(kj_bus), .kj_stb(kj_stb) );

	zkbdmus zkbdmus( .fclk(fclk), .rst_n(rst_n),
	                 .kbd_in(kbd_bus), .kbd_stb(kbd_stb),
	                 .kj_in(kj_bus), .kj_stb(kj_stb),
	                 .zah(a[15:8]),
	                 .kbd_data(kbd_port_data), .kj_data(kj_port_data) );

	zports zports( .fclk(fclk), .rst_n(rst_n),
	               .iorq_n(iorq_n), .rd_n(rd_n), .a(a),
	               .kbd_data(kbd_port_data), .kj_data(kj_port_data),
	               .dout(dout), .dataout(dataout) );

endmodule

//--- zkbdmus.sv
`timescale 1ns/100ps

module zkbdmus(
	input  logic                  fclk,
	input  logic                  rst_n,

	input  zkbd_pkg::kbd_matrix_u kbd_in,
	input  logic                  kbd_stb,
	input  logic [4:0]            kj_in,
	input  logic                  kj_stb,

	input  logic [7:0]            zah,
	output logic [4:0]            kbd_data,
	output logic [4:0]            kj_data
);

	import zkbd_pkg::*;

	kbd_matrix_u kbd_mat;
	logic [4:0]  kj_reg;

	////////////////////////////////////////////////////////////
	// stored state
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			kbd_mat.flat <= '1;
			kj_reg       <= 5'd0;
		end
		else
		begin
			if (kbd_stb)
				kbd_mat <= kbd_in;
			if (kj_stb)
				kj_reg <= kj_in;
		end
	end

	// rows picked by low bits of the high address
	always_comb
	begin
		kbd_data = '1;
		for (int r = 0; r < KBD_ROWS; r++)
		begin
			if (!zah[r])
				kbd_data = kbd_data & kbd_mat.rows[r];
		end
	end

	assign kj_data = kj_reg;

	a_kbd_load: assert property (@(posedge fclk) disable iff (!rst_n)
		kbd_stb |=> (kbd_mat.flat == $past(kbd_in.flat)));

endmodule

//--- zports.sv
`timescale 1ns/100ps

module zports(
	input  logic        fclk,
	input  logic        rst_n,

	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic [15:0] a,

	input  logic [4:0]  kbd_data,
	input  logic [4:0]  kj_data,

	output logic [7:0]  dout,
	output logic        dataout
);

	import zkbd_pkg::*;

	logic [1:0] iorq_sync;
	logic [1:0] rd_sync;

	logic       rd_cyc;
	logic       hit_kbd;
	logic       hit_kj;

	////////////////////////////////////////////////////////////
	// z80 strobes into fclk
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			iorq_sync <= 2'b11;
			rd_sync   <= 2'b11;
		end
		else
		begin
			iorq_sync <= {iorq_sync[0], iorq_n};
			rd_sync   <= {rd_sync[0], rd_n};
		end
	end

	assign rd_cyc  = ~iorq_sync[1] & ~rd_sync[1];
	assign hit_kbd = (a[7:0] == PORT_KBD);
	assign hit_kj  = (a[7:0] == PORT_KJ);

	////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			dataout <= 1'b0;
		else
			dataout <= rd_cyc & (hit_kbd | hit_kj);
	end

	// no tape input, upper bits of #FE float high
	always_ff @(posedge fclk)
	begin
		if (rd_cyc && hit_kbd)
			dout <= {3'b111, kbd_data};
		else if (rd_cyc && hit_kj)
			dout <= {3'b000, kj_data};
	end

	a_rd_iorq: assert property (@(posedge fclk) disable iff (!rst_n)
		dataout |-> $past(!iorq_sync[1]));

endmodule
